/* compile.f */
md_cart_pkg.sv
md_code_assembler.sv
md_code_fifo.sv
md_cheat_table.sv
md_region_detect.sv
md_cart_monitor.sv
md_handshake_props.sv
tb_md_cart_monitor.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cart monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_md_cart_monitor -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Keep running after an assertion error so the testbench prints its summary
output=$(./obj_dir/Vtb_md_cart_monitor +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx '>>> PASS' <<< "$output"; then
	exit 0
else
	exit 1
fi

/* tb_md_cart_monitor.sv */
////////////////////////////////////////////////////////////
// Testbench for the cartridge download monitor
// Clock and reset, stimulus tables for header regions,
// cheat codes and bus reads, checks and closing summary
////////////////////////////////////////////////////////////

module tb_md_cart_monitor;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int NUM_HDR        = 5;
	localparam int NUM_CODES      = 5;
	localparam int NUM_READS      = 13;

	localparam md_cart_pkg::region_t JP = md_cart_pkg::REGION_JP;
	localparam md_cart_pkg::region_t US = md_cart_pkg::REGION_US;
	localparam md_cart_pkg::region_t EU = md_cart_pkg::REGION_EU;

	logic                      clk_sys;
	logic                      sys_reset;
	logic                      dl_active;
	md_cart_pkg::dl_index_t    dl_index;
	logic                      dl_wr;
	md_cart_pkg::dl_addr_t     dl_addr;
	md_cart_pkg::dl_word_t     dl_data;
	md_cart_pkg::region_prio_t region_prio;
	logic                      cheats_en;
	md_cart_pkg::bus_addr_t    bus_addr;
	md_cart_pkg::bus_word_t    bus_data;
	md_cart_pkg::region_t      region_o;
	logic                      region_valid_o;
	logic                      code_avail_o;
	logic                      dl_wait_o;
	md_cart_pkg::bus_word_t    bus_data_o;

	int          checks;
	int          errors;
	int          timeouts;
	logic [31:0] rng_state;

	////////////////////////////////////////////////////////////
	// Stimulus tables
	////////////////////////////////////////////////////////////
	// Header words at 0x1F0 and 0x1F2 with the expected region per priority 0 to 3
	md_cart_pkg::dl_word_t hdr_w0 [NUM_HDR] = '{16'h2020, 16'h454A, 16'h2034, 16'h2043,
		16'h2020};
	md_cart_pkg::dl_word_t hdr_w1 [NUM_HDR] = '{16'h2055, 16'h2020, 16'h2020, 16'h2020,
		16'h2020};
	md_cart_pkg::region_t  hdr_exp [NUM_HDR][4] = '{
		'{US, US, US, US},
		'{EU, EU, JP, JP},
		'{US, US, US, US},
		'{US, EU, US, US},
		'{US, EU, US, JP}
	};

	// Code fields where the fifth code finds the table full
	logic [31:0] code_flags [NUM_CODES] = '{32'h0, 32'h1, 32'h8000_0002, 32'h0, 32'h0};
	logic [31:0] code_addr [NUM_CODES] = '{32'hAB00_1000, 32'h0000_2000, 32'h0000_3000,
		32'h0000_4000, 32'h0000_5000};
	logic [31:0] code_cmp [NUM_CODES] = '{32'h0, 32'h5A5A_1234, 32'h0000_0042, 32'h0, 32'h0};
	logic [31:0] code_repl [NUM_CODES] = '{32'hDEAD_BEEF, 32'h0000_5678, 32'h0000_1111,
		32'h0000_2222, 32'h0000_3333};

	// Bus reads with and without cheats enabled
	// Random rows pass through
	logic                   rd_en [NUM_READS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
		1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
	logic                   rd_rnd [NUM_READS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
		1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
	md_cart_pkg::bus_addr_t rd_addr [NUM_READS] = '{24'h001000, 24'h001000, 24'h002000,
		24'h002000, 24'h003000, 24'h004000, 24'h005000, 24'h001002, 24'h0, 24'h0,
		24'h001000, 24'h002000, 24'h0};
	md_cart_pkg::bus_word_t rd_data [NUM_READS] = '{16'h0000, 16'h7777, 16'h1234, 16'h1235,
		16'h9999, 16'h0042, 16'h0042, 16'h0000, 16'h0, 16'h0, 16'h0000, 16'h1234, 16'h0};
	md_cart_pkg::bus_word_t rd_exp [NUM_READS] = '{16'hBEEF, 16'hBEEF, 16'h5678, 16'h1235,
		16'h1111, 16'h2222, 16'h0042, 16'h0000, 16'h0, 16'h0, 16'h0000, 16'h1234, 16'h0};

	md_cart_monitor u_md_cart_monitor (
		.clk_sys        (clk_sys),
		.sys_reset      (sys_reset),
		.dl_active_i    (dl_active),
		.dl_index_i     (dl_index),
		.dl_wr_i        (dl_wr),
		.dl_addr_i      (dl_addr),
		.dl_data_i      (dl_data),
		.region_prio_i  (region_prio),
		.cheats_en_i    (cheats_en),
		.bus_addr_i     (bus_addr),
		.bus_data_i     (bus_data),
		.region_o       (region_o),
		.region_valid_o (region_valid_o),
		.code_avail_o   (code_avail_o),
		.dl_wait_o      (dl_wait_o),
		.bus_data_o     (bus_data_o)
	);

	bind md_code_fifo md_handshake_props u_handshake_props (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.code_clear_i (code_clear_i),
		.code_req_i   (code_req_i),
		.code_ack_i   (code_ack_o),
		.code_data_i  (code_data_i),
		.tbl_req_i    (tbl_req_o),
		.tbl_ack_i    (tbl_ack_i),
		.tbl_data_i   (tbl_data_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Offsets 0,2 flags, 4,6 address, 8,10 compare, 12,14 replace, low word first
	function automatic md_cart_pkg::dl_word_t code_word(input int k, input int off);
		logic [31:0] field;
		case (off / 4)
			0:       field = code_flags[k];
			1:       field = code_addr[k];
			2:       field = code_cmp[k];
			default: field = code_repl[k];
		endcase
		return ((off / 2) % 2 == 0) ? field[15:0] : field[31:16];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (expected == actual) else begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic finish_run;
		int prop_fails;
		prop_fails = u_md_cart_monitor.u_fifo.u_handshake_props.fail_cnt;
		$display("checks %0d, errors %0d, handshake assertion failures %0d, timeouts %0d",
			checks, errors, prop_fails, timeouts);
		if (errors == 0 && prop_fails == 0 && timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	task automatic wait_host_ready;
		int n;
		n = 0;
		while (dl_wait_o && n < TIMEOUT_CYCLES) begin
			@(negedge clk_sys);
			n++;
		end
		if (dl_wait_o) begin
			timeouts++;
			$display("Timeout: the host stall did not end after a code word");
		end
	endtask

	// Link B idle means the table has taken the last code
	task automatic wait_link_idle;
		int n;
		n = 0;
		while ((u_md_cart_monitor.tbl_req || u_md_cart_monitor.tbl_ack)
			&& n < TIMEOUT_CYCLES) begin
			@(negedge clk_sys);
			n++;
		end
		if (u_md_cart_monitor.tbl_req || u_md_cart_monitor.tbl_ack) begin
			timeouts++;
			$display("Timeout: the FIFO to table handshake did not return to idle");
		end
	endtask

	task automatic start_download(input md_cart_pkg::dl_index_t idx);
		dl_active = 1'b0;
		@(negedge clk_sys);
		dl_index  = idx;
		dl_active = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic host_write(input md_cart_pkg::dl_index_t idx,
		input md_cart_pkg::dl_addr_t addr, input md_cart_pkg::dl_word_t data);
		dl_index = idx;
		dl_addr  = addr;
		dl_data  = data;
		dl_wr    = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		wait_host_ready();
	endtask

	task automatic load_codes;
		start_download(md_cart_pkg::IDX_CODE);
		for (int k = 0; k < NUM_CODES; k++) begin
			for (int off = 0; off < 16; off += 2) begin
				host_write(md_cart_pkg::IDX_CODE, md_cart_pkg::dl_addr_t'(16 * k + off),
					code_word(k, off));
			end
			wait_link_idle();
		end
	endtask

	// Result shows up one cycle after the read is sampled
	task automatic bus_read(input string name, input logic en,
		input md_cart_pkg::bus_addr_t addr, input md_cart_pkg::bus_word_t data,
		input md_cart_pkg::bus_word_t expected);
		cheats_en = en;
		bus_addr  = addr;
		bus_data  = data;
		@(negedge clk_sys);
		check_value(name, 32'(expected), 32'(bus_data_o));
	endtask

	task automatic run_reads(input string phase, input logic cleared);
		md_cart_pkg::bus_addr_t addr;
		md_cart_pkg::bus_word_t data;
		md_cart_pkg::bus_word_t expected;
		for (int i = 0; i < NUM_READS; i++) begin
			if (rd_rnd[i]) begin
				rng_state = xorshift32(rng_state);
				// Top address bit set keeps random reads off every code
				addr      = {1'b1, rng_state[22:0]};
				rng_state = xorshift32(rng_state);
				data      = rng_state[15:0];
				expected  = data;
			end else begin
				addr     = rd_addr[i];
				data     = rd_data[i];
				expected = cleared ? data : rd_exp[i];
			end
			bus_read($sformatf("%s read %0d", phase, i), rd_en[i], addr, data, expected);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		checks      = 0;
		errors      = 0;
		timeouts    = 0;
		rng_state   = 32'd78370;
		sys_reset   = 1'b1;
		dl_active   = 1'b0;
		dl_index    = '0;
		dl_wr       = 1'b0;
		dl_addr     = '0;
		dl_data     = '0;
		region_prio = '0;
		cheats_en   = 1'b0;
		bus_addr    = '0;
		bus_data    = '0;
		repeat (3) @(negedge clk_sys);
		sys_reset = 1'b0;

		check_value("region_valid_o after reset", 32'd0, 32'(region_valid_o));
		check_value("code_avail_o after reset", 32'd0, 32'(code_avail_o));
		check_value("dl_wait_o after reset", 32'd0, 32'(dl_wait_o));
		for (int i = 0; i < 4; i++) begin
			rng_state = xorshift32(rng_state);
			bus_read($sformatf("empty table read %0d", i), 1'b1, rng_state[23:0],
				rng_state[31:16], rng_state[31:16]);
		end

		// Every header case under every priority
		for (int c = 0; c < NUM_HDR; c++) begin
			for (int p = 0; p < 4; p++) begin
				region_prio = md_cart_pkg::region_prio_t'(p);
				start_download(md_cart_pkg::IDX_CART);
				check_value($sformatf("valid low at cart start %0d/%0d", c, p), 32'd0,
					32'(region_valid_o));
				host_write(md_cart_pkg::IDX_CART, md_cart_pkg::HDR_REGION_ADDR, hdr_w0[c]);
				host_write(md_cart_pkg::IDX_CART, md_cart_pkg::HDR_REGION2_ADDR, hdr_w1[c]);
				host_write(md_cart_pkg::IDX_CART, md_cart_pkg::HDR_END_ADDR, 16'h0000);
				check_value($sformatf("region valid case %0d prio %0d", c, p), 32'd1,
					32'(region_valid_o));
				check_value($sformatf("region case %0d prio %0d", c, p), 32'(hdr_exp[c][p]),
					32'(region_o));
			end
		end

		load_codes();
		check_value("code_avail_o after load", 32'd1, 32'(code_avail_o));
		run_reads("loaded", 1'b0);

		// Restart of the cheat file empties the table
		host_write(md_cart_pkg::IDX_CODE, '0, 16'h0000);
		check_value("code_avail_o after clear", 32'd0, 32'(code_avail_o));
		run_reads("cleared", 1'b1);

		finish_run();
	end

endmodule

/* md_handshake_props.sv */
////////////////////////////////////////////////////////////
// Handshake assertions for both code FIFO links
// Req held until ack, no ack without req, stable data
////////////////////////////////////////////////////////////

module md_handshake_props (
	input logic                     clk_sys,
	input logic                     sys_reset,
	input logic                     code_clear_i,
	input logic                     code_req_i,
	input logic                     code_ack_i,
	input md_cart_pkg::cheat_code_t code_data_i,
	input logic                     tbl_req_i,
	input logic                     tbl_ack_i,
	input md_cart_pkg::cheat_code_t tbl_data_i
);

	int fail_cnt = 0;

	// Link A from assembler to FIFO
	a_code_req_held: assert property (@(posedge clk_sys)
		disable iff (sys_reset || code_clear_i)
		code_req_i && !code_ack_i |=> code_req_i)
		else begin
			$error("link A req dropped before ack");
			fail_cnt++;
		end
	a_code_ack_needs_req: assert property (@(posedge clk_sys)
		disable iff (sys_reset || code_clear_i)
		$rose(code_ack_i) |-> code_req_i)
		else begin
			$error("link A ack rose without req");
			fail_cnt++;
		end
	a_code_data_stable: assert property (@(posedge clk_sys)
		disable iff (sys_reset || code_clear_i)
		code_req_i && $past(code_req_i) |-> $stable(code_data_i))
		else begin
			$error("link A data changed while req was high");
			fail_cnt++;
		end

	// Link B from FIFO to table
	a_tbl_req_held: assert property (@(posedge clk_sys)
		disable iff (sys_reset || code_clear_i)
		tbl_req_i && !tbl_ack_i |=> tbl_req_i)
		else begin
			$error("link B req dropped before ack");
			fail_cnt++;
		end
	a_tbl_ack_needs_req: assert property (@(posedge clk_sys)
		disable iff (sys_reset || code_clear_i)
		$rose(tbl_ack_i) |-> tbl_req_i)
		else begin
			$error("link B ack rose without req");
			fail_cnt++;
		end
	a_tbl_data_stable: assert property (@(posedge clk_sys)
		disable iff (sys_reset || code_clear_i)
		tbl_req_i && $past(tbl_req_i) |-> $stable(tbl_data_i))
		else begin
			$error("link B data changed while req was high");
			fail_cnt++;
		end

endmodule

/* md_cart_monitor.sv */
////////////////////////////////////////////////////////////
// Cartridge download monitor top level
// Code assembler, code FIFO, cheat table, region detect
////////////////////////////////////////////////////////////

module md_cart_monitor (
	input  logic                      clk_sys,
	input  logic                      sys_reset,
	input  logic                      dl_active_i,
	input  md_cart_pkg::dl_index_t    dl_index_i,
	input  logic                      dl_wr_i,
	input  md_cart_pkg::dl_addr_t     dl_addr_i,
	input  md_cart_pkg::dl_word_t     dl_data_i,
	input  md_cart_pkg::region_prio_t region_prio_i,
	input  logic                      cheats_en_i,
	input  md_cart_pkg::bus_addr_t    bus_addr_i,
	input  md_cart_pkg::bus_word_t    bus_data_i,
	output md_cart_pkg::region_t      region_o,
	output logic                      region_valid_o,
	output logic                      code_avail_o,
	output logic                      dl_wait_o,
	output md_cart_pkg::bus_word_t    bus_data_o
);

	// Link A
	logic                     code_req;
	logic                     code_ack;
	md_cart_pkg::cheat_code_t code_data;
	logic                     code_clear;

	// Link B
	logic                     tbl_req;
	logic                     tbl_ack;
	md_cart_pkg::cheat_code_t tbl_data;

	md_code_assembler u_assembler (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.dl_active_i  (dl_active_i),
		.dl_index_i   (dl_index_i),
		.dl_wr_i      (dl_wr_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.code_ack_i   (code_ack),
		.code_req_o   (code_req),
		.code_data_o  (code_data),
		.code_clear_o (code_clear),
		.dl_wait_o    (dl_wait_o)
	);

	md_code_fifo u_fifo (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.code_clear_i (code_clear),
		.code_req_i   (code_req),
		.code_data_i  (code_data),
		.tbl_ack_i    (tbl_ack),
		.code_ack_o   (code_ack),
		.tbl_req_o    (tbl_req),
		.tbl_data_o   (tbl_data)
	);

	md_cheat_table u_table (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.code_clear_i (code_clear),
		.tbl_req_i    (tbl_req),
		.tbl_data_i   (tbl_data),
		.cheats_en_i  (cheats_en_i),
		.bus_addr_i   (bus_addr_i),
		.bus_data_i   (bus_data_i),
		.tbl_ack_o    (tbl_ack),
		.code_avail_o (code_avail_o),
		.bus_data_o   (bus_data_o)
	);

	md_region_detect u_region (
		.clk_sys        (clk_sys),
		.sys_reset      (sys_reset),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.dl_wr_i        (dl_wr_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.region_prio_i  (region_prio_i),
		.region_o       (region_o),
		.region_valid_o (region_valid_o)
	);

endmodule

/* md_region_detect.sv */
////////////////////////////////////////////////////////////
// Console region detection
// Parses header region characters, picks region by priority
////////////////////////////////////////////////////////////

module md_region_detect (
	input  logic                      clk_sys,
	input  logic                      sys_reset,
	input  logic                      dl_active_i,
	input  md_cart_pkg::dl_index_t    dl_index_i,
	input  logic                      dl_wr_i,
	input  md_cart_pkg::dl_addr_t     dl_addr_i,
	input  md_cart_pkg::dl_word_t     dl_data_i,
	input  md_cart_pkg::region_prio_t region_prio_i,
	output md_cart_pkg::region_t      region_o,
	output logic                      region_valid_o
);

	logic       cart_dl;
	logic       cart_dl_q;
	logic       cart_start;
	logic       cart_wr;
	logic [7:0] lo_byte;
	logic [7:0] hex_adj;
	// Bit order is {E, U, J}
	logic [2:0] flags;
	logic [2:0] flags_nxt;

	assign cart_dl    = dl_active_i && (dl_index_i == md_cart_pkg::IDX_CART);
	assign cart_start = cart_dl && !cart_dl_q;
	assign cart_wr    = cart_dl && dl_wr_i;
	assign lo_byte    = dl_data_i[7:0];
	assign hex_adj    = lo_byte - 8'd7;

	function automatic logic [2:0] letter_flag(input logic [7:0] ch);
		case (ch)
			"J":     letter_flag = 3'b001;
			"U":     letter_flag = 3'b010;
			"E":     letter_flag = 3'b100;
			default: letter_flag = 3'b000;
		endcase
	endfunction

	function automatic md_cart_pkg::region_t pick_region(
		input md_cart_pkg::region_prio_t prio,
		input logic [2:0]                euj
	);
		case (prio)
			md_cart_pkg::PRIO_US_EU_JP:
				pick_region = euj[1] ? md_cart_pkg::REGION_US :
					euj[2] ? md_cart_pkg::REGION_EU :
					euj[0] ? md_cart_pkg::REGION_JP : md_cart_pkg::REGION_US;
			md_cart_pkg::PRIO_EU_US_JP:
				pick_region = euj[2] ? md_cart_pkg::REGION_EU :
					euj[1] ? md_cart_pkg::REGION_US :
					euj[0] ? md_cart_pkg::REGION_JP : md_cart_pkg::REGION_EU;
			md_cart_pkg::PRIO_US_JP_EU:
				pick_region = euj[1] ? md_cart_pkg::REGION_US :
					euj[0] ? md_cart_pkg::REGION_JP :
					euj[2] ? md_cart_pkg::REGION_EU : md_cart_pkg::REGION_US;
			default:
				pick_region = euj[0] ? md_cart_pkg::REGION_JP :
					euj[1] ? md_cart_pkg::REGION_US :
					euj[2] ? md_cart_pkg::REGION_EU : md_cart_pkg::REGION_JP;
		endcase
	endfunction

	always_comb begin
		flags_nxt = flags;
		if (cart_wr && (dl_addr_i == md_cart_pkg::HDR_REGION_ADDR)) begin
			// Digit or hex code replaces the whole set
			if (lo_byte >= "0" && lo_byte <= "9") begin
				flags_nxt = {lo_byte[3], lo_byte[2], lo_byte[0]};
			end else if (lo_byte >= "A" && lo_byte <= "F") begin
				flags_nxt = {hex_adj[3], hex_adj[2], hex_adj[0]};
			end else begin
				flags_nxt = flags | letter_flag(lo_byte);
			end
			flags_nxt = flags_nxt | letter_flag(dl_data_i[15:8]);
		end
		if (cart_wr && (dl_addr_i == md_cart_pkg::HDR_REGION2_ADDR)) begin
			flags_nxt = flags | letter_flag(lo_byte);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			cart_dl_q      <= 1'b0;
			flags          <= '0;
			region_o       <= md_cart_pkg::REGION_US;
			region_valid_o <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_start) begin
				flags          <= '0;
				region_valid_o <= 1'b0;
			end else begin
				flags <= flags_nxt;
			end
			// Flags are complete by the end of the header
			if (cart_wr && (dl_addr_i == md_cart_pkg::HDR_END_ADDR)) begin
				region_o       <= pick_region(region_prio_i, flags);
				region_valid_o <= 1'b1;
			end
		end
	end

endmodule

/* md_cheat_table.sv */
////////////////////////////////////////////////////////////
// Cheat table
// Stores codes from link B in slots and patches 68k reads
////////////////////////////////////////////////////////////

module md_cheat_table (
	input  logic                     clk_sys,
	input  logic                     sys_reset,
	input  logic                     code_clear_i,
	input  logic                     tbl_req_i,
	input  md_cart_pkg::cheat_code_t tbl_data_i,
	input  logic                     cheats_en_i,
	input  md_cart_pkg::bus_addr_t   bus_addr_i,
	input  md_cart_pkg::bus_word_t   bus_data_i,
	output logic                     tbl_ack_o,
	output logic                     code_avail_o,
	output md_cart_pkg::bus_word_t   bus_data_o
);

	localparam int AW = $bits(md_cart_pkg::bus_addr_t);
	localparam int DW = $bits(md_cart_pkg::bus_word_t);

	md_cart_pkg::cheat_code_t slot_code [md_cart_pkg::CODE_SLOTS];

	logic [md_cart_pkg::CODE_SLOTS-1:0] slot_vld;
	logic [md_cart_pkg::CODE_SLOTS-1:0] slot_hit;
	logic [md_cart_pkg::SLOT_IDX_W-1:0] slot_cnt;
	logic                               slot_full;
	logic                               new_req;
	logic                               take;
	md_cart_pkg::bus_word_t             patched;

	assign slot_full = &slot_vld;
	assign new_req   = tbl_req_i && !tbl_ack_o;
	// Codes beyond the last slot are acked and dropped
	assign take      = new_req && !slot_full && !code_clear_i;

	////////////////////////////////////////////////////////////
	// Link B receiver and slot fill
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (take) begin
			slot_code[slot_cnt] <= tbl_data_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset || code_clear_i) begin
			tbl_ack_o    <= 1'b0;
			code_avail_o <= 1'b0;
			slot_vld     <= '0;
			slot_cnt     <= '0;
		end else begin
			if (new_req) begin
				tbl_ack_o <= 1'b1;
			end else if (tbl_ack_o && !tbl_req_i) begin
				tbl_ack_o <= 1'b0;
			end
			if (take) begin
				slot_vld[slot_cnt] <= 1'b1;
				slot_cnt           <= slot_cnt + 1'b1;
				code_avail_o       <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read patching
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < md_cart_pkg::CODE_SLOTS; i++) begin : g_slot
		logic addr_match;
		logic cmp_ok;

		assign addr_match = slot_code[i][md_cart_pkg::CODE_ADDR_LSB +: AW] == bus_addr_i;
		assign cmp_ok = !slot_code[i][md_cart_pkg::CODE_FLAGS_LSB + md_cart_pkg::CODE_FLAG_CMP]
			|| (slot_code[i][md_cart_pkg::CODE_CMP_LSB +: DW] == bus_data_i);
		assign slot_hit[i] = slot_vld[i] && cheats_en_i && addr_match && cmp_ok;
	end

	// Walk down so the lowest hitting slot wins
	always_comb begin
		patched = bus_data_i;
		for (int i = md_cart_pkg::CODE_SLOTS - 1; i >= 0; i--) begin
			if (slot_hit[i]) begin
				patched = slot_code[i][md_cart_pkg::CODE_REPL_LSB +: DW];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		bus_data_o <= patched;
	end

endmodule

/* md_code_fifo.sv */
////////////////////////////////////////////////////////////
// Two-entry cheat code FIFO
// Four-phase req/ack receiver on link A, sender on link B
////////////////////////////////////////////////////////////

module md_code_fifo (
	input  logic                     clk_sys,
	input  logic                     sys_reset,
	input  logic                     code_clear_i,
	input  logic                     code_req_i,
	input  md_cart_pkg::cheat_code_t code_data_i,
	input  logic                     tbl_ack_i,
	output logic                     code_ack_o,
	output logic                     tbl_req_o,
	output md_cart_pkg::cheat_code_t tbl_data_o
);

	md_cart_pkg::cheat_code_t entry [md_cart_pkg::FIFO_DEPTH];

	logic [md_cart_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [md_cart_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic [md_cart_pkg::FIFO_PTR_W:0]   count;
	logic                               push;
	logic                               pop;

	// Full FIFO holds back ack, which stalls the host
	assign push = code_req_i && !code_ack_o && (count != md_cart_pkg::FIFO_FULL);
	assign pop  = tbl_req_o && tbl_ack_i;

	// Head entry is never the write target while req is up
	assign tbl_data_o = entry[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (push) begin
			entry[wr_ptr] <= code_data_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset || code_clear_i) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			code_ack_o <= 1'b0;
			tbl_req_o  <= 1'b0;
		end else begin
			// Link A receiver
			if (push) begin
				wr_ptr     <= wr_ptr + 1'b1;
				code_ack_o <= 1'b1;
			end else if (code_ack_o && !code_req_i) begin
				code_ack_o <= 1'b0;
			end

			// Link B sender raises the next req only after ack has dropped
			if (pop) begin
				rd_ptr    <= rd_ptr + 1'b1;
				tbl_req_o <= 1'b0;
			end else if (!tbl_req_o && !tbl_ack_i && (count != '0)) begin
				tbl_req_o <= 1'b1;
			end

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* md_code_assembler.sv */
////////////////////////////////////////////////////////////
// Cheat code assembler
// Collects download words into 128-bit codes, offers them
// on a four-phase req/ack link, derives the code clear pulse
////////////////////////////////////////////////////////////

module md_code_assembler (
	input  logic                     clk_sys,
	input  logic                     sys_reset,
	input  logic                     dl_active_i,
	input  md_cart_pkg::dl_index_t   dl_index_i,
	input  logic                     dl_wr_i,
	input  md_cart_pkg::dl_addr_t    dl_addr_i,
	input  md_cart_pkg::dl_word_t    dl_data_i,
	input  logic                     code_ack_i,
	output logic                     code_req_o,
	output md_cart_pkg::cheat_code_t code_data_o,
	output logic                     code_clear_o,
	output logic                     dl_wait_o
);

	typedef enum logic [1:0] {
		ASM_IDLE,
		ASM_REQ,
		ASM_ACK_LOW
	} asm_state_t;

	asm_state_t state;
	logic       cart_dl;
	logic       cart_dl_q;
	logic       code_wr;
	logic       last_word;
	logic [6:0] word_lsb;

	assign cart_dl   = dl_active_i && (dl_index_i == md_cart_pkg::IDX_CART);
	assign code_wr   = dl_active_i && (dl_index_i == md_cart_pkg::IDX_CODE) && dl_wr_i;
	assign last_word = code_wr && (dl_addr_i[3:0] == 4'd14);

	// Offset 0 is the flags low word, offset 14 the replace high word
	assign word_lsb = {~dl_addr_i[3:2], dl_addr_i[1], 4'b0000};

	// Start of a cart load or a cheat file restarting at address 0
	assign code_clear_o = (cart_dl && !cart_dl_q) || (code_wr && (dl_addr_i == '0));

	always_ff @(posedge clk_sys) begin
		if (state == ASM_IDLE && code_wr) begin
			code_data_o[word_lsb +: $bits(md_cart_pkg::dl_word_t)] <= dl_data_i;
		end
	end

	////////////////////////////////////////////////////////////
	// Link A sender
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			state      <= ASM_IDLE;
			code_req_o <= 1'b0;
			dl_wait_o  <= 1'b0;
			cart_dl_q  <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			case (state)
				ASM_IDLE: begin
					if (last_word) begin
						code_req_o <= 1'b1;
						dl_wait_o  <= 1'b1;
						state      <= ASM_REQ;
					end
				end
				ASM_REQ: begin
					if (code_ack_i) begin
						code_req_o <= 1'b0;
						state      <= ASM_ACK_LOW;
					end
				end
				ASM_ACK_LOW: begin
					// Host resumes once the FIFO has let go of ack
					if (!code_ack_i) begin
						dl_wait_o <= 1'b0;
						state     <= ASM_IDLE;
					end
				end
				default: state <= ASM_IDLE;
			endcase
			// Clear abandons a code in flight
			if (code_clear_o) begin
				code_req_o <= 1'b0;
				dl_wait_o  <= 1'b0;
				state      <= ASM_IDLE;
			end
		end
	end

endmodule

/* md_cart_pkg.sv */
////////////////////////////////////////////////////////////
// Shared widths, types and constants for the cart monitor
// Download stream, cheat code layout, region encodings
////////////////////////////////////////////////////////////

package md_cart_pkg;

	// Host download stream
	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] dl_word_t;
	typedef logic [7:0]  dl_index_t;

	// Flags, address, compare, replace from the top
	typedef logic [127:0] cheat_code_t;

	// 68k bus side
	typedef logic [23:0] bus_addr_t;
	typedef logic [15:0] bus_word_t;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	typedef logic [1:0] region_prio_t;

	// Priority orders
	localparam region_prio_t PRIO_US_EU_JP = 2'd0;
	localparam region_prio_t PRIO_EU_US_JP = 2'd1;
	localparam region_prio_t PRIO_US_JP_EU = 2'd2;
	localparam region_prio_t PRIO_JP_US_EU = 2'd3;

	// Cheat table and code FIFO sizing
	localparam int CODE_SLOTS = 4;
	localparam int SLOT_IDX_W = $clog2(CODE_SLOTS);
	localparam int FIFO_DEPTH = 2;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam logic [FIFO_PTR_W:0] FIFO_FULL = (FIFO_PTR_W + 1)'(FIFO_DEPTH);

	// File indices
	localparam dl_index_t IDX_CART = 8'd1;
	localparam dl_index_t IDX_CODE = 8'd255;

	// Cartridge header addresses
	localparam dl_addr_t HDR_REGION_ADDR  = 25'h1F0;
	localparam dl_addr_t HDR_REGION2_ADDR = 25'h1F2;
	localparam dl_addr_t HDR_END_ADDR     = 25'h200;

	// Field positions inside a cheat code
	localparam int CODE_FLAGS_LSB = 96;
	localparam int CODE_ADDR_LSB  = 64;
	localparam int CODE_CMP_LSB   = 32;
	localparam int CODE_REPL_LSB  = 0;
	localparam int CODE_FLAG_CMP  = 0;

endpackage
